//--- src/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [16:0] sram_addr_t;  // SRAM word address
    typedef logic [3:0]  reg_idx_t;

    // Memory opcode from execute
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // SRAM controller states
    typedef enum logic [1:0] {
        S_IDLE  = 2'b00,
        S_READ  = 2'b01,
        S_WRITE = 2'b10
    } sram_state_e;

    // Data space starts here, below is instruction space
    localparam word_t DATA_BASE = 32'd1024;

    // Request from execute stage
    typedef struct packed {
        mem_op_e  op;
        word_t    address;     // Byte address, word aligned
        word_t    store_data;
        word_t    alu_result;  // Result for non-load ops
        reg_idx_t dest;
        logic     wb_en;
    } mem_req_t;

    // Record handed to write-back
    typedef struct packed {
        logic     wb_en;
        reg_idx_t dest;
        word_t    value;
    } wb_t;

endpackage

//--- src/sram_ctrl.sv
`timescale 1ns/10ps

module sram_ctrl #(
    parameter int unsigned WAIT_CYCLES = 5
) (
    input  logic                 clk,
    input  logic                 rst,

    // Request side
    input  mem_pkg::mem_op_e     op,
    input  mem_pkg::word_t       address,
    input  mem_pkg::word_t       store_data,
    output mem_pkg::word_t       read_data,
    output logic                 ready,

    // SRAM pins
    output mem_pkg::sram_addr_t  sram_addr,
    output mem_pkg::word_t       sram_wdata,
    input  mem_pkg::word_t       sram_rdata,
    output logic                 sram_we_n
);
    import mem_pkg::*;

    localparam logic [2:0] WAIT_LAST = 3'(WAIT_CYCLES);

    sram_state_e state;
    sram_state_e state_next;
    logic [2:0]  count;
    logic [2:0]  count_next;
    logic        busy;
    logic        start;
    word_t       offset;

    // Access still inside its wait window
    assign busy  = (state != S_IDLE) && (count != WAIT_LAST);
    assign start = (state == S_IDLE) && (op != MEM_NONE);

    always_comb begin
        state_next = state;
        count_next = 3'd0;
        case (state)
            S_IDLE: begin
                if (op == MEM_LOAD) begin
                    state_next = S_READ;
                end else if (op == MEM_STORE) begin
                    state_next = S_WRITE;
                end
            end
            S_READ, S_WRITE: begin
                if (busy) begin
                    count_next = count + 3'd1;
                end else begin
                    state_next = S_IDLE;  // Last cycle with valid data
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            count <= 3'd0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    // Ready drops as soon as a request shows up in idle
    assign ready = !(busy || start);

    // Word address relative to data base
    assign offset    = address - DATA_BASE;
    assign sram_addr = offset[18:2];

    assign sram_wdata = store_data;
    assign sram_we_n  = !((state == S_WRITE) && busy);  // Held low over the wait window
    assign read_data  = sram_rdata;

    a_addr_legal: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (address >= DATA_BASE) && (address[1:0] == 2'b00)
    ) else $error("sram_ctrl: illegal data address %h", address);

    // Request source must hold the request while stalled
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        !ready |=> $stable(op) && $stable(address)
    ) else $error("sram_ctrl: request changed under freeze");

    a_we_in_write: assert property (
        @(posedge clk) disable iff (rst)
        !sram_we_n |-> (state == S_WRITE)
    ) else $error("sram_ctrl: write enable outside S_WRITE");

    // Freeze is exactly WAIT_CYCLES+1 cycles per access
    a_access_len: assert property (
        @(posedge clk) disable iff (rst)
        start |=> (!ready) [*WAIT_CYCLES] ##1 ready
    ) else $error("sram_ctrl: access length wrong");

endmodule

//--- src/mem_stage.sv
`timescale 1ns/10ps

module mem_stage #(
    parameter int unsigned WAIT_CYCLES = 5
) (
    input  logic                 clk,
    input  logic                 rst,

    // From execute
    input  mem_pkg::mem_req_t    req,
    output logic                 freeze,

    // To write-back
    output mem_pkg::wb_t         wb,

    // SRAM pins
    output mem_pkg::sram_addr_t  sram_addr,
    output mem_pkg::word_t       sram_wdata,
    input  mem_pkg::word_t       sram_rdata,
    output logic                 sram_we_n
);
    import mem_pkg::*;

    logic  ready;
    word_t read_data;
    wb_t   wb_next;

    sram_ctrl #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_sram_ctrl (
        .clk        (clk),
        .rst        (rst),
        .op         (req.op),
        .address    (req.address),
        .store_data (req.store_data),
        .read_data  (read_data),
        .ready      (ready),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .sram_we_n  (sram_we_n)
    );

    // Whole pipeline stalls while the access runs
    assign freeze = !ready;

    // Write-back value select
    always_comb begin
        wb_next.wb_en = req.wb_en && (req.op != MEM_STORE);  // Stores write no register
        wb_next.dest  = req.dest;
        if (req.op == MEM_LOAD) begin
            wb_next.value = read_data;
        end else begin
            wb_next.value = req.alu_result;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (ready) begin
            wb.dest  <= wb_next.dest;
            wb.value <= wb_next.value;
        end
        if (rst) begin
            wb.wb_en <= 1'b0;
        end else begin
            wb.wb_en <= ready && wb_next.wb_en;  // Bubble while frozen
        end
    end

    // Back-to-back records only from non-memory requests,
    // a memory op always leaves a bubble ahead of its record
    a_one_record: assert property (
        @(posedge clk) disable iff (rst)
        (wb.wb_en && $past(wb.wb_en)) |-> ($past(req.op) == MEM_NONE)
    ) else $error("mem_stage: repeated record for a frozen request");

endmodule

//--- src/mem_top.sv
`timescale 1ns/10ps

module mem_top #(
    parameter int unsigned WAIT_CYCLES = 5
) (
    input  logic                 clk,
    input  logic                 rst,

    // Execute stage side
    input  mem_pkg::mem_req_t    req,
    output logic                 freeze,

    // Write-back side
    output mem_pkg::wb_t         wb,

    // External asynchronous SRAM
    output mem_pkg::sram_addr_t  sram_addr,
    output mem_pkg::word_t       sram_wdata,
    input  mem_pkg::word_t       sram_rdata,
    output logic                 sram_we_n
);
    import mem_pkg::*;

    mem_req_t   req_w;
    wb_t        wb_w;
    logic       freeze_w;
    sram_addr_t sram_addr_w;
    word_t      sram_wdata_w;
    logic       sram_we_n_w;

    assign req_w = req;

    mem_stage #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .req        (req_w),
        .freeze     (freeze_w),
        .wb         (wb_w),
        .sram_addr  (sram_addr_w),
        .sram_wdata (sram_wdata_w),
        .sram_rdata (sram_rdata),
        .sram_we_n  (sram_we_n_w)
    );

    assign freeze     = freeze_w;
    assign wb         = wb_w;
    assign sram_addr  = sram_addr_w;   // No extra pipelining on the pins
    assign sram_wdata = sram_wdata_w;
    assign sram_we_n  = sram_we_n_w;

endmodule

//--- dv/sram_model.sv
`timescale 1ns/10ps

module sram_model (
    input  logic                clk,
    input  mem_pkg::sram_addr_t sram_addr,
    input  mem_pkg::word_t      sram_wdata,
    output mem_pkg::word_t      sram_rdata,
    input  logic                sram_we_n
);
    import mem_pkg::*;

    localparam int DEPTH = 131072;  // 2**17 words

    word_t mem [DEPTH];

    // Power-up contents, a different word at every address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i) * 32'h9E37_79B9 + 32'h0F1E_2D3C;
        end
    end

    assign sram_rdata = mem[sram_addr];  // Asynchronous read

    always @(posedge clk) begin
        if (!sram_we_n) begin
            mem[sram_addr] = sram_wdata;
        end
    end

endmodule

//--- dv/tb_mem_top.sv
`timescale 1ns/10ps

module tb_mem_top;
    import mem_pkg::*;

    localparam int WAIT_CYCLES = 5;
    localparam int CLK_PERIOD  = 10;
    localparam int RESET_LEN   = 8;
    localparam int TABLE_LEN   = 13;
    localparam int RAND_OPS    = 40;
    localparam int ACCESS_LEN  = WAIT_CYCLES + 1;  // Freeze cycles per load or store

    typedef struct packed {
        mem_req_t req;
        wb_t      exp;
    } vec_t;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    logic        freeze;
    wb_t         wb;
    sram_addr_t  sram_addr;
    word_t       sram_wdata;
    word_t       sram_rdata;
    logic        sram_we_n;

    vec_t        vectors [TABLE_LEN];
    word_t       ref_mem [sram_addr_t];
    int unsigned lcg_state;
    int          errors;
    int          checks;
    int          tests;
    int          recs_seen;
    int          recs_exp;

    mem_top #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .freeze     (freeze),
        .wb         (wb),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .sram_we_n  (sram_we_n)
    );

    sram_model u_sram (
        .clk        (clk),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .sram_we_n  (sram_we_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Count every valid record leaving the stage
    always @(negedge clk) begin
        if (!rst && wb.wb_en) begin
            recs_seen++;
        end
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // (address - 1024) / 4
    function automatic sram_addr_t word_index(word_t address);
        word_t off;
        off = address - DATA_BASE;
        return sram_addr_t'(off >> 2);
    endfunction

    function automatic word_t fill_word(sram_addr_t a);
        return word_t'(a) * 32'h9E37_79B9 + 32'h0F1E_2D3C;
    endfunction

    function automatic word_t ref_read(sram_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic vec_t make_vec(mem_op_e op, word_t address, word_t store_data,
                                      word_t alu_result, reg_idx_t dest, logic wb_en,
                                      word_t load_value);
        vec_t v;
        v.req.op         = op;
        v.req.address    = address;
        v.req.store_data = store_data;
        v.req.alu_result = alu_result;
        v.req.dest       = dest;
        v.req.wb_en      = wb_en;
        v.exp.wb_en      = wb_en && (op != MEM_STORE);
        v.exp.dest       = dest;
        v.exp.value      = (op == MEM_LOAD) ? load_value : alu_result;
        return v;
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got.wb_en !== exp.wb_en || (exp.wb_en && got !== exp)) begin
            errors++;
            $display("ERR %0t wb: got en=%b dest=%0d value=%h exp en=%b dest=%0d value=%h",
                     $time, got.wb_en, got.dest, got.value, exp.wb_en, exp.dest, exp.value);
        end
    endtask

    task automatic check_addr(input sram_addr_t got, input sram_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t sram_addr: got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t %s: got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    // Drive one request at a falling edge and follow it until its record shows on wb
    task automatic apply(input vec_t v);
        int   frz;
        logic store;
        frz   = 0;
        store = (v.req.op == MEM_STORE);
        req   = v.req;
        #1;
        while (freeze) begin
            frz++;
            if (frz > 1) begin
                check_bit("wb.wb_en", wb.wb_en, 1'b0);  // Bubble while frozen
            end
            check_addr(sram_addr, word_index(v.req.address));
            check_bit("sram_we_n", sram_we_n, !(store && frz > 1));
            if (store && frz > 1) begin
                check_word("sram_wdata", sram_wdata, v.req.store_data);
            end
            @(negedge clk);
            #1;
        end
        check_bit("sram_we_n", sram_we_n, 1'b1);  // Released in the last access cycle
        check_count("freeze", frz, (v.req.op == MEM_NONE) ? 0 : ACCESS_LEN);
        @(negedge clk);
        check_wb(wb, v.exp);
        if (v.exp.wb_en) begin
            recs_exp++;
        end
        if (store) begin
            ref_mem[word_index(v.req.address)] = v.req.store_data;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        vectors[0]  = make_vec(MEM_NONE,  32'h0, 32'h0, 32'h1111_2222, 4'd3, 1'b1, 32'h0);
        vectors[1]  = make_vec(MEM_NONE,  32'h0, 32'h0, 32'h0000_0005, 4'd4, 1'b0, 32'h0);
        vectors[2]  = make_vec(MEM_STORE, 32'h408, 32'hCAFE_F00D, 32'h408, 4'd5, 1'b1, 32'h0);
        vectors[3]  = make_vec(MEM_LOAD,  32'h408, 32'h0, 32'h0, 4'd6, 1'b1, 32'hCAFE_F00D);
        vectors[4]  = make_vec(MEM_STORE, 32'h400, 32'h2468_ACE0, 32'h0, 4'd0, 1'b0, 32'h0);
        vectors[5]  = make_vec(MEM_STORE, 32'h4CD0, 32'h0BAD_BEEF, 32'h0, 4'd9, 1'b1, 32'h0);
        vectors[6]  = make_vec(MEM_NONE,  32'h0, 32'h0, 32'h0000_0077, 4'd7, 1'b1, 32'h0);
        vectors[7]  = make_vec(MEM_LOAD,  32'h4CD0, 32'h0, 32'h0, 4'd8, 1'b1, 32'h0BAD_BEEF);
        vectors[8]  = make_vec(MEM_STORE, 32'h8_03FC, 32'h1357_9BDF, 32'h0, 4'd10, 1'b1, 32'h0);
        vectors[9]  = make_vec(MEM_LOAD,  32'h8_03FC, 32'h0, 32'h0, 4'd15, 1'b1, 32'h1357_9BDF);
        vectors[10] = make_vec(MEM_LOAD,  32'h400, 32'h0, 32'h0, 4'd11, 1'b1, 32'h2468_ACE0);
        vectors[11] = make_vec(MEM_LOAD,  32'h408, 32'h0, 32'h0, 4'd1, 1'b1, 32'hCAFE_F00D);
        vectors[12] = make_vec(MEM_NONE,  32'h0, 32'h0, 32'hFFFF_FFFF, 4'd2, 1'b1, 32'h0);
    end

    initial begin
        int         errs_before;
        word_t      r;
        word_t      address;
        logic [3:0] idx;
        mem_op_e    op;
        vec_t       v;

        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        lcg_state = 73763;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        recs_seen = 0;
        recs_exp  = 0;

        repeat (RESET_LEN) @(negedge clk);
        rst = 1'b0;
        #1;
        errs_before = errors;
        check_bit("freeze", freeze, 1'b0);
        check_bit("wb.wb_en", wb.wb_en, 1'b0);
        check_bit("sram_we_n", sram_we_n, 1'b1);
        report("reset state", errs_before);
        @(negedge clk);

        for (int i = 0; i < TABLE_LEN; i++) begin
            errs_before = errors;
            apply(vectors[i]);
            report($sformatf("vector %0d %s", i, vectors[i].req.op.name()), errs_before);
        end

        // Random loads and stores over 16 words
        for (int i = 0; i < RAND_OPS; i++) begin
            errs_before = errors;
            r       = lcg_next();
            idx     = r[19:16];
            op      = r[31] ? MEM_LOAD : MEM_STORE;
            address = DATA_BASE + word_t'(idx) * 32'h2204;
            v = make_vec(op, address, lcg_next(), lcg_next(), r[27:24], 1'b1,
                         ref_read(word_index(address)));
            apply(v);
            report($sformatf("random %0d %s word %0d", i, op.name(), idx), errs_before);
        end

        // Idle request so no record repeats
        req = '0;
        repeat (3) @(negedge clk);
        errs_before = errors;
        check_count("wb.wb_en records", recs_seen, recs_exp);
        report("record count", errs_before);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((RESET_LEN + (TABLE_LEN + RAND_OPS) * (WAIT_CYCLES + 2) + 50) * CLK_PERIOD);
        $display("Watchdog: run did not finish within its cycle budget");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- all.f
src/mem_pkg.sv
src/sram_ctrl.sv
src/mem_stage.sv
src/mem_top.sv
dv/sram_model.sv
dv/tb_mem_top.sv

//--- run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_top -f all.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
